// ==== verilog/mac_seg_pkg.sv ====
package mac_seg_pkg;

    // Segment geometry of the hard MAC side.
    localparam int seg_count = 4;   // Segments per MAC word.
    localparam int seg_bytes = 8;   // Bytes per segment, same as the MFB block.

    // Word geometry, shared by the MFB and the MAC side.
    localparam int word_bytes = seg_count * seg_bytes;
    localparam int word_width = word_bytes * 8;

    // MFB position fields.
    // Start of frame points at a block, end of frame points at a byte.
    localparam int sof_pos_width = $clog2(seg_count);
    localparam int eof_pos_width = $clog2(word_bytes);

    // Empty byte count reported on the last-byte segment.
    localparam int empty_width = $clog2(seg_bytes);

    // One data word, seen either as a flat vector or as MAC segments.
    // Segment 0 holds the lowest bytes of the word.
    typedef union packed {
        logic [word_width-1:0]                  flat;
        logic [seg_count-1:0][seg_bytes*8-1:0]  seg;
    } seg_data_t;

endpackage

// ==== verilog/mfb_seg_decoder.sv ====
`timescale 1ns/1ps

module mfb_seg_decoder import mac_seg_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   reset,

    // MFB word and framing flags.
    input  seg_data_t                              data,
    input  logic                                   sof,
    input  logic [sof_pos_width-1:0]               sof_pos,
    input  logic                                   eof,
    input  logic [eof_pos_width-1:0]               eof_pos,
    input  logic                                   error,
    input  logic                                   accept,    // Word transfers this cycle.

    // Per-segment view of the same word.
    output seg_data_t                              seg_data,
    output logic [seg_count-1:0]                   seg_inframe,
    output logic [seg_count-1:0][empty_width-1:0]  seg_eop_empty,
    output logic [seg_count-1:0]                   seg_error
);

    logic                      inframe_q;    // A frame is running at the start of the word.
    logic                      inframe_d;
    logic [sof_pos_width-1:0]  eof_blk;      // Block that holds the last byte.
    logic [empty_width-1:0]    eof_off;      // Byte offset of the last byte in that block.
    logic [seg_count-1:0]      run_seg;      // Segment carries bytes of the running frame.
    logic [seg_count-1:0]      last_seg;     // Segment holds the last byte of the running frame.
    logic [seg_count-1:0]      new_seg;      // Segment carries bytes of a frame started here.

    assign eof_blk = eof_pos[eof_pos_width-1:empty_width];
    assign eof_off = eof_pos[empty_width-1:0];

    // Classify each segment of the word.
    // An eof only applies to a frame that was already running, since a
    // frame is long enough never to start and end in the same word.
    always_comb begin
        for (int i = 0; i < seg_count; i++) begin
            run_seg[i]  = inframe_q && (!eof || sof_pos_width'(i) < eof_blk);
            last_seg[i] = inframe_q && eof && sof_pos_width'(i) == eof_blk;
            new_seg[i]  = sof && sof_pos_width'(i) >= sof_pos;
        end
    end

    // Segment flags as the MAC expects them.
    always_comb begin
        seg_data.flat = data.flat;    // Payload is not touched.
        for (int i = 0; i < seg_count; i++) begin
            // The flag drops on the last-byte segment, which marks the frame end.
            seg_inframe[i] = (run_seg[i] || new_seg[i]) && !last_seg[i];

            // 7 minus offset, written as the bitwise inverse of the offset.
            seg_eop_empty[i] = last_seg[i] ? ~eof_off : '0;

            seg_error[i] = last_seg[i] && error;    // FCS error only at frame end.
        end
    end

    // The word leaves a frame open when a new frame starts after the
    // end of the old one, or when the old one just continues.
    always_comb begin
        inframe_d = sof || (inframe_q && !eof);
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            inframe_q <= 1'b0;
        end else if (accept) begin
            inframe_q <= inframe_d;
        end
    end

endmodule

// ==== verilog/mac_seg_skid_buffer.sv ====
`timescale 1ns/1ps

module mac_seg_skid_buffer import mac_seg_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   reset,

    // Upstream side.
    input  seg_data_t                              in_data,
    input  logic [seg_count-1:0]                   in_inframe,
    input  logic [seg_count-1:0][empty_width-1:0]  in_eop_empty,
    input  logic [seg_count-1:0]                   in_error,
    input  logic                                   in_valid,
    output logic                                   in_ready,

    // Downstream side, driven from the main register.
    output seg_data_t                              out_data,
    output logic [seg_count-1:0]                   out_inframe,
    output logic [seg_count-1:0][empty_width-1:0]  out_eop_empty,
    output logic [seg_count-1:0]                   out_error,
    output logic                                   out_valid,
    input  logic                                   out_ready
);

    logic                                   main_valid;
    logic                                   skid_valid;
    logic                                   main_valid_d;
    logic                                   skid_valid_d;
    logic                                   ready_q;
    logic                                   in_xfer;      // Upstream word accepted.
    logic                                   main_load;    // Main register takes a new word.
    logic                                   skid_load;    // Incoming word parks in the skid.
    seg_data_t                              skid_data;
    logic [seg_count-1:0]                   skid_inframe;
    logic [seg_count-1:0][empty_width-1:0]  skid_eop_empty;
    logic [seg_count-1:0]                   skid_error;

    assign in_xfer   = in_valid && in_ready;
    assign main_load = !main_valid || out_ready;    // Main is empty or drains now.
    assign skid_load = in_xfer && main_valid && !out_ready;

    always_comb begin
        main_valid_d = main_load ? (skid_valid || in_xfer) : main_valid;
        if (skid_valid) begin
            skid_valid_d = !out_ready;    // Skid moves to main when main drains.
        end else begin
            skid_valid_d = skid_load;
        end
    end

    // Ready follows an empty skid register, one cycle late out of reset.
    always_ff @(posedge CLK) begin
        if (reset) begin
            main_valid  <= 1'b0;
            skid_valid  <= 1'b0;
            ready_q     <= 1'b0;
            out_inframe <= '0;
        end else begin
            main_valid <= main_valid_d;
            skid_valid <= skid_valid_d;
            ready_q    <= !skid_valid_d;
            if (main_load) begin
                out_inframe <= skid_valid ? skid_inframe : in_inframe;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (main_load) begin
            for (int i = 0; i < seg_count; i++) begin
                out_data.seg[i] <= skid_valid ? skid_data.seg[i] : in_data.seg[i];
            end
            out_eop_empty <= skid_valid ? skid_eop_empty : in_eop_empty;
            out_error     <= skid_valid ? skid_error : in_error;
        end
        if (skid_load) begin
            for (int i = 0; i < seg_count; i++) begin
                skid_data.seg[i] <= in_data.seg[i];
            end
            skid_inframe   <= in_inframe;
            skid_eop_empty <= in_eop_empty;
            skid_error     <= in_error;
        end
    end

    assign in_ready  = ready_q;
    assign out_valid = main_valid;

endmodule

// ==== verilog/tx_mac_seg_adapter.sv ====
`timescale 1ns/1ps

module tx_mac_seg_adapter import mac_seg_pkg::*; (
    input  logic                                   CLK,
    input  logic                                   reset,

    // MFB input, one region of four blocks.
    input  seg_data_t                              mfb_data,
    input  logic                                   mfb_sof,
    input  logic [sof_pos_width-1:0]               mfb_sof_pos,
    input  logic                                   mfb_eof,
    input  logic [eof_pos_width-1:0]               mfb_eof_pos,
    input  logic                                   mfb_error,
    input  logic                                   mfb_src_rdy,
    output logic                                   mfb_dst_rdy,

    // Segmented MAC output.
    output seg_data_t                              mac_data,
    output logic [seg_count-1:0]                   mac_inframe,
    output logic [seg_count-1:0][empty_width-1:0]  mac_eop_empty,
    output logic [seg_count-1:0]                   mac_error,
    output logic                                   mac_valid,
    input  logic                                   mac_ready
);

    // Decoded word on its way into the skid buffer.
    seg_data_t                              dec_data;
    logic [seg_count-1:0]                   dec_inframe;
    logic [seg_count-1:0][empty_width-1:0]  dec_eop_empty;
    logic [seg_count-1:0]                   dec_error;

    mfb_seg_decoder decoder_i (
        .CLK           (CLK),
        .reset         (reset),
        .data          (mfb_data),
        .sof           (mfb_sof),
        .sof_pos       (mfb_sof_pos),
        .eof           (mfb_eof),
        .eof_pos       (mfb_eof_pos),
        .error         (mfb_error),
        .accept        (mfb_src_rdy && mfb_dst_rdy),    // Frame state moves on transfer only.
        .seg_data      (dec_data),
        .seg_inframe   (dec_inframe),
        .seg_eop_empty (dec_eop_empty),
        .seg_error     (dec_error)
    );

    // Output register stage, also the source of MFB back-pressure.
    mac_seg_skid_buffer skid_i (
        .CLK           (CLK),
        .reset         (reset),
        .in_data       (dec_data),
        .in_inframe    (dec_inframe),
        .in_eop_empty  (dec_eop_empty),
        .in_error      (dec_error),
        .in_valid      (mfb_src_rdy),
        .in_ready      (mfb_dst_rdy),
        .out_data      (mac_data),
        .out_inframe   (mac_inframe),
        .out_eop_empty (mac_eop_empty),
        .out_error     (mac_error),
        .out_valid     (mac_valid),
        .out_ready     (mac_ready)
    );

endmodule

// ==== sim/mac_seg_sva.sv ====
`timescale 1ns/1ps

module mac_seg_sva import mac_seg_pkg::*; (
    input logic                                   CLK,
    input logic                                   reset,
    input logic                                   mfb_dst_rdy,
    input seg_data_t                              mac_data,
    input logic [seg_count-1:0]                   mac_inframe,
    input logic [seg_count-1:0][empty_width-1:0]  mac_eop_empty,
    input logic [seg_count-1:0]                   mac_error,
    input logic                                   mac_valid,
    input logic                                   mac_ready
);

    int                    fail_count = 0;    // Read at the end of the run.
    logic [seg_count-1:0]  empty_set;         // Segment reports a nonzero empty count.

    always_comb begin
        for (int i = 0; i < seg_count; i++) begin
            empty_set[i] = |mac_eop_empty[i];
        end
    end

    // A stalled word stays put until the MAC takes it.
    hold_stable: assert property (@(posedge CLK) disable iff (reset)
        mac_valid && !mac_ready |=> mac_valid && $stable(mac_data) && $stable(mac_inframe)
            && $stable(mac_eop_empty) && $stable(mac_error))
        else begin
            $error("MAC word changed while stalled");
            fail_count++;
        end

    valid_in_reset: assert property (@(posedge CLK) reset |=> !mac_valid)
        else begin
            $error("mac_valid high after a reset cycle");
            fail_count++;
        end

    // Error and empty count only on a segment where the in-frame flag has dropped.
    error_on_last: assert property (@(posedge CLK) disable iff (reset)
        mac_valid |-> (mac_error & mac_inframe) == '0 && $onehot0(mac_error)
            && (empty_set & mac_inframe) == '0)
        else begin
            $error("mac_error or empty count outside a last-byte segment");
            fail_count++;
        end

    // MFB back-pressure only with words held.
    stall_with_data: assert property (@(posedge CLK) disable iff (reset)
        !$past(reset) && !mfb_dst_rdy |-> mac_valid)
        else begin
            $error("mfb_dst_rdy low with no word held");
            fail_count++;
        end

endmodule

bind tx_mac_seg_adapter mac_seg_sva sva_i (.*);

// ==== sim/testbench.sv ====
`timescale 1ns/1ps

module testbench import mac_seg_pkg::*; ();

    localparam int record_words = 11;    // Tokens per record in the pattern file.
    localparam int max_records  = 64;
    localparam int reset_cycles = 5;

    logic                                   CLK;
    logic                                   reset;
    seg_data_t                              mfb_data;
    logic                                   mfb_sof;
    logic [sof_pos_width-1:0]               mfb_sof_pos;
    logic                                   mfb_eof;
    logic [eof_pos_width-1:0]               mfb_eof_pos;
    logic                                   mfb_error;
    logic                                   mfb_src_rdy;
    logic                                   mfb_dst_rdy;
    seg_data_t                              mac_data;
    logic [seg_count-1:0]                   mac_inframe;
    logic [seg_count-1:0][empty_width-1:0]  mac_eop_empty;
    logic [seg_count-1:0]                   mac_error;
    logic                                   mac_valid;
    logic                                   mac_ready;

    // Input tokens 0..6, expected tokens 7..10 of each record.
    logic [word_width-1:0]  pattern_mem [0:record_words*max_records-1];

    int           num_records = 0;
    int           cycle_limit = 0;
    int           cycle_count = 0;
    int           cur_record  = 0;              // Record currently on the MFB inputs.
    int           expected_q[$];                // Records accepted but not yet seen on MAC.
    logic [31:0]  rng_state   = 32'h546b6bb0;
    bit           ready_armed = 1'b0;

    tx_mac_seg_adapter DUT (
        .CLK           (CLK),
        .reset         (reset),
        .mfb_data      (mfb_data),
        .mfb_sof       (mfb_sof),
        .mfb_sof_pos   (mfb_sof_pos),
        .mfb_eof       (mfb_eof),
        .mfb_eof_pos   (mfb_eof_pos),
        .mfb_error     (mfb_error),
        .mfb_src_rdy   (mfb_src_rdy),
        .mfb_dst_rdy   (mfb_dst_rdy),
        .mac_data      (mac_data),
        .mac_inframe   (mac_inframe),
        .mac_eop_empty (mac_eop_empty),
        .mac_error     (mac_error),
        .mac_valid     (mac_valid),
        .mac_ready     (mac_ready)
    );

    always #50 CLK = ~CLK;    // 100 ns period.

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic compare_value(input string name, input logic [word_width-1:0] actual,
                                 input logic [word_width-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Put one record on the MFB inputs.
    task automatic drive_record(input int r);
        int base;
        base = r * record_words;
        mfb_src_rdy   <= pattern_mem[base][0];
        mfb_sof       <= pattern_mem[base+1][0];
        mfb_sof_pos   <= pattern_mem[base+2][sof_pos_width-1:0];
        mfb_eof       <= pattern_mem[base+3][0];
        mfb_eof_pos   <= pattern_mem[base+4][eof_pos_width-1:0];
        mfb_error     <= pattern_mem[base+5][0];
        mfb_data.flat <= pattern_mem[base+6];
        cur_record    <= r;
    endtask

    // Compare the MAC word against the expected half of record r.
    task automatic verify_output(input int r);
        int base;
        base = r * record_words + 7;
        for (int i = 0; i < seg_count; i++) begin
            compare_value($sformatf("mac_data.seg[%0d]", i), mac_data.seg[i],
                          pattern_mem[base][seg_bytes*8*i +: seg_bytes*8]);
        end
        compare_value("mac_inframe", mac_inframe, pattern_mem[base+1][seg_count-1:0]);
        for (int i = 0; i < seg_count; i++) begin
            // One hex digit per segment in the file.
            compare_value($sformatf("mac_eop_empty[%0d]", i), mac_eop_empty[i],
                          pattern_mem[base+2][4*i +: empty_width]);
        end
        compare_value("mac_error", mac_error, pattern_mem[base+3][seg_count-1:0]);
    endtask

    // Random MAC back-pressure, low about one cycle in three.
    always @(posedge CLK) begin
        rng_state = xorshift32(rng_state);
        mac_ready <= (rng_state % 3) != 0;
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            abort_run($sformatf("Timeout: the run did not finish within %0d cycles",
                                cycle_limit));
        end
    end

    // Both handshakes are sampled at the edge, before any update lands.
    initial begin
        @(posedge CLK);
        forever begin
            int held;
            @(posedge CLK);
            held = expected_q.size();
            if (reset) begin
                compare_value("mac_valid", mac_valid, 1'b0);
            end else begin
                if (mac_valid && mac_ready) begin
                    if (held == 0) begin
                        abort_run("The MAC side delivered a word that was never sent");
                    end
                    verify_output(expected_q.pop_front());
                end
                if (mfb_src_rdy && mfb_dst_rdy) begin
                    expected_q.push_back(cur_record);
                end
                // Ready is still low in the first cycle out of reset.
                if (ready_armed && !mfb_dst_rdy) begin
                    compare_value("words pending at mfb_dst_rdy low", held, 2);
                end
                ready_armed = 1'b1;
            end
        end
    end

    initial begin
        CLK           = 1'b0;
        reset         = 1'b1;
        mfb_data.flat = '0;
        mfb_sof       = 1'b0;
        mfb_sof_pos   = '0;
        mfb_eof       = 1'b0;
        mfb_eof_pos   = '0;
        mfb_error     = 1'b0;
        mfb_src_rdy   = 1'b0;
        mac_ready     = 1'b0;

        $readmemh("sim/mac_seg_patterns.txt", pattern_mem);
        while (num_records < max_records &&
               !$isunknown(pattern_mem[num_records * record_words])) begin
            num_records++;
        end
        if (num_records == 0) begin
            abort_run("No pattern records found in sim/mac_seg_patterns.txt");
        end
        cycle_limit = 4 * num_records + 50;

        repeat (reset_cycles) @(posedge CLK);
        reset <= 1'b0;

        for (int r = 0; r < num_records; r++) begin
            drive_record(r);
            @(posedge CLK);
            while (mfb_src_rdy && !mfb_dst_rdy) begin
                @(posedge CLK);
            end
        end
        mfb_src_rdy <= 1'b0;

        // Let the last accepted word reach the queue, then drain it.
        @(negedge CLK);
        while (expected_q.size() != 0) begin
            @(negedge CLK);
        end
        @(negedge CLK);
        compare_value("mac_valid", mac_valid, 1'b0);    // Nothing extra left over.

        if (DUT.sva_i.fail_count != 0) begin
            abort_run($sformatf("%0d handshake assertions fired during the run",
                                DUT.sva_i.fail_count));
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// ==== sim/mac_seg_patterns.txt ====
// Two lines per record. Input: src_rdy sof sof_pos eof eof_pos error data.
// Expected: data, in-frame (bit per segment), empty (hex digit per segment,
// segment 3 first), error (bit per segment). Idle records carry zeros.
// Frame of three words from block 0, ends at byte 21.
1 1 0 0 00 0 a5a50003f0e1d2c3a5a50002f0e1d2c3a5a50001f0e1d2c3a5a50000f0e1d2c3
a5a50003f0e1d2c3a5a50002f0e1d2c3a5a50001f0e1d2c3a5a50000f0e1d2c3 f 0000 0
1 0 0 0 00 0 a5a50103f0e1d2c3a5a50102f0e1d2c3a5a50101f0e1d2c3a5a50100f0e1d2c3
a5a50103f0e1d2c3a5a50102f0e1d2c3a5a50101f0e1d2c3a5a50100f0e1d2c3 f 0000 0
1 0 0 1 15 0 a5a50203f0e1d2c3a5a50202f0e1d2c3a5a50201f0e1d2c3a5a50200f0e1d2c3
a5a50203f0e1d2c3a5a50202f0e1d2c3a5a50201f0e1d2c3a5a50200f0e1d2c3 3 0200 0
0 0 0 0 00 0 0
0 0 0 0
1 1 0 0 00 0 a5a50403f0e1d2c3a5a50402f0e1d2c3a5a50401f0e1d2c3a5a50400f0e1d2c3
a5a50403f0e1d2c3a5a50402f0e1d2c3a5a50401f0e1d2c3a5a50400f0e1d2c3 f 0000 0
1 0 0 0 00 0 a5a50503f0e1d2c3a5a50502f0e1d2c3a5a50501f0e1d2c3a5a50500f0e1d2c3
a5a50503f0e1d2c3a5a50502f0e1d2c3a5a50501f0e1d2c3a5a50500f0e1d2c3 f 0000 0
// Errored end in block 1, next frame from block 2.
1 1 2 1 0f 1 a5a50603f0e1d2c3a5a50602f0e1d2c3a5a50601f0e1d2c3a5a50600f0e1d2c3
a5a50603f0e1d2c3a5a50602f0e1d2c3a5a50601f0e1d2c3a5a50600f0e1d2c3 d 0000 2
1 0 0 0 00 0 a5a50703f0e1d2c3a5a50702f0e1d2c3a5a50701f0e1d2c3a5a50700f0e1d2c3
a5a50703f0e1d2c3a5a50702f0e1d2c3a5a50701f0e1d2c3a5a50700f0e1d2c3 f 0000 0
1 0 0 1 18 0 a5a50803f0e1d2c3a5a50802f0e1d2c3a5a50801f0e1d2c3a5a50800f0e1d2c3
a5a50803f0e1d2c3a5a50802f0e1d2c3a5a50801f0e1d2c3a5a50800f0e1d2c3 7 7000 0
1 1 0 0 00 0 a5a50903f0e1d2c3a5a50902f0e1d2c3a5a50901f0e1d2c3a5a50900f0e1d2c3
a5a50903f0e1d2c3a5a50902f0e1d2c3a5a50901f0e1d2c3a5a50900f0e1d2c3 f 0000 0
1 0 0 0 00 0 a5a50a03f0e1d2c3a5a50a02f0e1d2c3a5a50a01f0e1d2c3a5a50a00f0e1d2c3
a5a50a03f0e1d2c3a5a50a02f0e1d2c3a5a50a01f0e1d2c3a5a50a00f0e1d2c3 f 0000 0
1 1 1 1 06 0 a5a50b03f0e1d2c3a5a50b02f0e1d2c3a5a50b01f0e1d2c3a5a50b00f0e1d2c3
a5a50b03f0e1d2c3a5a50b02f0e1d2c3a5a50b01f0e1d2c3a5a50b00f0e1d2c3 e 0001 0
1 0 0 0 00 0 a5a50c03f0e1d2c3a5a50c02f0e1d2c3a5a50c01f0e1d2c3a5a50c00f0e1d2c3
a5a50c03f0e1d2c3a5a50c02f0e1d2c3a5a50c01f0e1d2c3a5a50c00f0e1d2c3 f 0000 0
// Block 2 idle between the end and the new start.
1 1 3 1 0c 0 a5a50d03f0e1d2c3a5a50d02f0e1d2c3a5a50d01f0e1d2c3a5a50d00f0e1d2c3
a5a50d03f0e1d2c3a5a50d02f0e1d2c3a5a50d01f0e1d2c3a5a50d00f0e1d2c3 9 0030 0
1 0 0 0 00 0 a5a50e03f0e1d2c3a5a50e02f0e1d2c3a5a50e01f0e1d2c3a5a50e00f0e1d2c3
a5a50e03f0e1d2c3a5a50e02f0e1d2c3a5a50e01f0e1d2c3a5a50e00f0e1d2c3 f 0000 0
1 1 3 1 13 1 a5a50f03f0e1d2c3a5a50f02f0e1d2c3a5a50f01f0e1d2c3a5a50f00f0e1d2c3
a5a50f03f0e1d2c3a5a50f02f0e1d2c3a5a50f01f0e1d2c3a5a50f00f0e1d2c3 b 0400 4
1 0 0 0 00 0 a5a51003f0e1d2c3a5a51002f0e1d2c3a5a51001f0e1d2c3a5a51000f0e1d2c3
a5a51003f0e1d2c3a5a51002f0e1d2c3a5a51001f0e1d2c3a5a51000f0e1d2c3 f 0000 0
1 0 0 1 19 0 a5a51103f0e1d2c3a5a51102f0e1d2c3a5a51101f0e1d2c3a5a51100f0e1d2c3
a5a51103f0e1d2c3a5a51102f0e1d2c3a5a51101f0e1d2c3a5a51100f0e1d2c3 7 6000 0
0 0 0 0 00 0 0
0 0 0 0
1 1 0 0 00 0 a5a51303f0e1d2c3a5a51302f0e1d2c3a5a51301f0e1d2c3a5a51300f0e1d2c3
a5a51303f0e1d2c3a5a51302f0e1d2c3a5a51301f0e1d2c3a5a51300f0e1d2c3 f 0000 0
1 0 0 0 00 0 a5a51403f0e1d2c3a5a51402f0e1d2c3a5a51401f0e1d2c3a5a51400f0e1d2c3
a5a51403f0e1d2c3a5a51402f0e1d2c3a5a51401f0e1d2c3a5a51400f0e1d2c3 f 0000 0
1 0 0 1 02 0 a5a51503f0e1d2c3a5a51502f0e1d2c3a5a51501f0e1d2c3a5a51500f0e1d2c3
a5a51503f0e1d2c3a5a51502f0e1d2c3a5a51501f0e1d2c3a5a51500f0e1d2c3 0 0005 0

// ==== compile.f ====
verilog/mac_seg_pkg.sv
verilog/mfb_seg_decoder.sv
verilog/mac_seg_skid_buffer.sv
verilog/tx_mac_seg_adapter.sv
sim/mac_seg_sva.sv
sim/testbench.sv

// ==== Bender.yml ====
package:
  name: tx_mac_seg_adapter

sources:
  # Synthesizable RTL in compile order.
  - files:
      - verilog/mac_seg_pkg.sv
      - verilog/mfb_seg_decoder.sv
      - verilog/mac_seg_skid_buffer.sv
      - verilog/tx_mac_seg_adapter.sv

  # Assertions and testbench top.
  - target: simulation
    files:
      - sim/mac_seg_sva.sv
      - sim/testbench.sv
